// File: common/aim_defines.svh
`ifndef AIM_DEFINES_SVH
`define AIM_DEFINES_SVH

// Visible area, which is also the frame buffer size.
`define AIM_H_ACTIVE 32
`define AIM_V_ACTIVE 16

// Clocks per line and lines per frame, blanking included.
`define AIM_H_TOTAL 40
`define AIM_V_TOTAL 20

// Sync pulses, first and last counter value.
`define AIM_HS_START 34
`define AIM_HS_END 36
`define AIM_VS_START 17
`define AIM_VS_END 18

// Widths of the pixel and line counters.
`define AIM_X_W 6
`define AIM_Y_W 5

`define AIM_FB_AW 9

// Overlay boxes and border thickness.
`define AIM_N_BOX 2
`define AIM_H_BOX_WIDTH 2
`define AIM_V_BOX_WIDTH 1

`endif

// File: common/aim_pkg.sv
`default_nettype none

`include "aim_defines.svh"

package aim_pkg;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // One overlay box, inclusive corners.
    typedef struct packed {
        logic                en;
        logic [`AIM_X_W-1:0] xs;
        logic [`AIM_X_W-1:0] xe;
        logic [`AIM_Y_W-1:0] ys;
        logic [`AIM_Y_W-1:0] ye;
        rgb888_t             color;
    } box_cfg_t;

    typedef enum logic [2:0] {
        REG_XS    = 3'd0,
        REG_YS    = 3'd1,
        REG_XE    = 3'd2,
        REG_YE    = 3'd3,
        REG_COLOR = 3'd4,
        REG_CTRL  = 3'd5
    } box_reg_e;

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_HI,
        CAP_LO
    } cap_state_e;

endpackage

`default_nettype wire

// File: common/pix_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "aim_defines.svh"

interface pix_if;
    import aim_pkg::*;

    logic                hsync;
    logic                vsync;
    logic                de;
    logic [`AIM_X_W-1:0] x;
    logic [`AIM_Y_W-1:0] y;
    rgb888_t             pix;

    modport src (
        output hsync,
        output vsync,
        output de,
        output x,
        output y,
        output pix
    );

    modport sink (
        input hsync,
        input vsync,
        input de,
        input x,
        input y,
        input pix
    );

endinterface

`default_nettype wire

// File: display/box_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "aim_defines.svh"

module box_regs (
    input  wire                                   clk,
    input  wire                                   i_rst,
    input  wire                                   i_reg_we,
    input  wire  [3:0]                            i_reg_addr,
    input  wire  [23:0]                           i_reg_wdata,
    input  wire                                   i_frame_start,
    output aim_pkg::box_cfg_t [`AIM_N_BOX-1:0]    o_boxes
);
    import aim_pkg::*;

    localparam int N_BOX = `AIM_N_BOX;

    box_cfg_t [N_BOX-1:0] pend;
    box_reg_e             field;
    logic                 box_sel;

    assign field   = box_reg_e'(i_reg_addr[2:0]);
    assign box_sel = i_reg_addr[3];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pend    <= '0;
            o_boxes <= '0;
        end else begin
            if (i_reg_we) begin
                for (int b = 0; b < N_BOX; b++) begin
                    if (int'(box_sel) == b) begin
                        case (field)
                            REG_XS:    pend[b].xs    <= i_reg_wdata[`AIM_X_W-1:0];
                            REG_YS:    pend[b].ys    <= i_reg_wdata[`AIM_Y_W-1:0];
                            REG_XE:    pend[b].xe    <= i_reg_wdata[`AIM_X_W-1:0];
                            REG_YE:    pend[b].ye    <= i_reg_wdata[`AIM_Y_W-1:0];
                            REG_COLOR: pend[b].color <= i_reg_wdata;
                            REG_CTRL:  pend[b].en    <= i_reg_wdata[0];
                            default:   ;
                        endcase
                    end
                end
            end
            // Whole boxes change only between frames.
            if (i_frame_start) begin
                o_boxes <= pend;
            end
        end
    end

endmodule

`default_nettype wire

// File: display/draw_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "aim_defines.svh"

module draw_window (
    input  wire                                    clk,
    input  wire                                    i_rst,
    input  wire aim_pkg::box_cfg_t [`AIM_N_BOX-1:0] i_boxes,
    pix_if.sink                                    i_pix,
    output logic                                   o_hsync,
    output logic                                   o_vsync,
    output logic                                   o_de,
    output logic [7:0]                             o_r,
    output logic [7:0]                             o_g,
    output logic [7:0]                             o_b
);
    import aim_pkg::*;

    localparam int N_BOX = `AIM_N_BOX;

    logic    hit;
    rgb888_t hit_color;
    rgb888_t out_pix;

    function automatic logic on_border(
        input box_cfg_t            box,
        input logic [`AIM_X_W-1:0] x,
        input logic [`AIM_Y_W-1:0] y
    );
        logic in_x;
        logic in_y;
        logic edge_x;
        logic edge_y;
        in_x   = (x >= box.xs) && (x <= box.xe);
        in_y   = (y >= box.ys) && (y <= box.ye);
        edge_x = ((int'(x) - int'(box.xs)) < `AIM_H_BOX_WIDTH) ||
                 ((int'(box.xe) - int'(x)) < `AIM_H_BOX_WIDTH);
        edge_y = ((int'(y) - int'(box.ys)) < `AIM_V_BOX_WIDTH) ||
                 ((int'(box.ye) - int'(y)) < `AIM_V_BOX_WIDTH);
        return box.en && in_x && in_y && (edge_x || edge_y);
    endfunction

    // Walk from the last box down so box 0 has the final say.
    always_comb begin
        hit       = 1'b0;
        hit_color = '0;
        for (int b = N_BOX - 1; b >= 0; b--) begin
            if (i_pix.de && on_border(i_boxes[b], i_pix.x, i_pix.y)) begin
                hit       = 1'b1;
                hit_color = i_boxes[b].color;
            end
        end
    end

    assign out_pix = hit ? hit_color : i_pix.pix;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_hsync <= 1'b0;
            o_vsync <= 1'b0;
            o_de    <= 1'b0;
        end else begin
            o_hsync <= i_pix.hsync;
            o_vsync <= i_pix.vsync;
            o_de    <= i_pix.de;
        end
    end

    always_ff @(posedge clk) begin
        o_r <= out_pix.r;
        o_g <= out_pix.g;
        o_b <= out_pix.b;
    end

endmodule

`default_nettype wire

// File: display/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "aim_defines.svh"

module video_timing (
    input  wire                    clk,
    input  wire                    i_rst,
    input  wire aim_pkg::rgb565_t  i_rdata,
    output logic [`AIM_FB_AW-1:0]  o_raddr,
    output logic                   o_frame_start,
    pix_if.src                     o_pix
);
    import aim_pkg::*;

    localparam int FB_AW = `AIM_FB_AW;

    logic [`AIM_X_W-1:0] h_cnt;
    logic [`AIM_Y_W-1:0] v_cnt;
    logic                active;
    logic                hs;
    logic                vs;
    logic                de_q;
    logic                hs_q;
    logic                vs_q;
    logic [`AIM_X_W-1:0] x_q;
    logic [`AIM_Y_W-1:0] y_q;
    rgb888_t             exp_pix;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == `AIM_H_TOTAL - 1) begin
            h_cnt <= '0;
            if (v_cnt == `AIM_V_TOTAL - 1) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign active = (h_cnt < `AIM_H_ACTIVE) && (v_cnt < `AIM_V_ACTIVE);
    assign hs     = (h_cnt >= `AIM_HS_START) && (h_cnt <= `AIM_HS_END);
    assign vs     = (v_cnt >= `AIM_VS_START) && (v_cnt <= `AIM_VS_END);

    assign o_raddr       = active ? FB_AW'(v_cnt) * FB_AW'(`AIM_H_ACTIVE) + FB_AW'(h_cnt) : '0;
    assign o_frame_start = (h_cnt == '0) && (v_cnt == '0);

    // Control follows the memory by one stage.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            de_q <= 1'b0;
            hs_q <= 1'b0;
            vs_q <= 1'b0;
        end else begin
            de_q <= active;
            hs_q <= hs;
            vs_q <= vs;
        end
    end

    always_ff @(posedge clk) begin
        x_q <= h_cnt;
        y_q <= v_cnt;
    end

    always_comb begin
        exp_pix.r = {i_rdata.r, 3'b000};
        exp_pix.g = {i_rdata.g, 2'b00};
        exp_pix.b = {i_rdata.b, 3'b000};
    end

    assign o_pix.hsync = hs_q;
    assign o_pix.vsync = vs_q;
    assign o_pix.de    = de_q;
    assign o_pix.x     = x_q;
    assign o_pix.y     = y_q;
    assign o_pix.pix   = de_q ? exp_pix : '0;

endmodule

`default_nettype wire

// File: sim/tb_aim_video_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "aim_defines.svh"

module tb_aim_video_top;
    import aim_pkg::*;

    localparam int H_ACT        = `AIM_H_ACTIVE;
    localparam int V_ACT        = `AIM_V_ACTIVE;
    localparam int N_PIX        = H_ACT * V_ACT;
    localparam int N_BOX        = `AIM_N_BOX;
    localparam int FRAME_CYCLES = `AIM_H_TOTAL * `AIM_V_TOTAL;
    localparam int HS_WIDTH     = `AIM_HS_END - `AIM_HS_START + 1;
    localparam int VS_WIDTH     = (`AIM_VS_END - `AIM_VS_START + 1) * `AIM_H_TOTAL;
    // About 17 frames in the worst case, with a few more as margin.
    localparam int TIMEOUT_CYCLES = 20 * FRAME_CYCLES;

    logic        clk = 1'b0;
    logic        i_rst;
    logic        i_cam_vsync;
    logic        i_cam_href;
    logic        i_cam_byte_en;
    logic [7:0]  i_cam_data;
    logic        i_reg_we;
    logic [3:0]  i_reg_addr;
    logic [23:0] i_reg_wdata;
    logic        o_hdmi_hsync;
    logic        o_hdmi_vsync;
    logic        o_hdmi_de;
    logic [7:0]  o_hdmi_r;
    logic [7:0]  o_hdmi_g;
    logic [7:0]  o_hdmi_b;

    // Picture and box settings as the display should show them.
    logic [15:0] m_img   [0:V_ACT-1][0:H_ACT-1];
    box_cfg_t    m_pend  [0:N_BOX-1];
    box_cfg_t    m_act   [0:N_BOX-1];

    bit check_armed;
    bit check_en;
    bit seen_vs;
    int de_cnt;
    int de_run;
    int de_lines;
    int hs_run;
    int vs_run;
    int frames_done;
    int cycles;
    int n_err;
    int n_checks;

    aim_video_top DUT (
        .clk          (clk          ),
        .i_rst        (i_rst        ),
        .i_cam_vsync  (i_cam_vsync  ),
        .i_cam_href   (i_cam_href   ),
        .i_cam_byte_en(i_cam_byte_en),
        .i_cam_data   (i_cam_data   ),
        .i_reg_we     (i_reg_we     ),
        .i_reg_addr   (i_reg_addr   ),
        .i_reg_wdata  (i_reg_wdata  ),
        .o_hdmi_hsync (o_hdmi_hsync ),
        .o_hdmi_vsync (o_hdmi_vsync ),
        .o_hdmi_de    (o_hdmi_de    ),
        .o_hdmi_r     (o_hdmi_r     ),
        .o_hdmi_g     (o_hdmi_g     ),
        .o_hdmi_b     (o_hdmi_b     )
    );

    always #5 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [23:0] want,
                                   input logic [23:0] got);
        n_err++;
        $display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, want, got);
    endtask

    function automatic bit on_box_border(input box_cfg_t bx, input int x, input int y);
        int xs;
        int xe;
        int ys;
        int ye;
        xs = bx.xs;
        xe = bx.xe;
        ys = bx.ys;
        ye = bx.ye;
        if (!bx.en || x < xs || x > xe || y < ys || y > ye) begin
            return 1'b0;
        end
        return (x - xs < `AIM_H_BOX_WIDTH) || (xe - x < `AIM_H_BOX_WIDTH) ||
               (y - ys < `AIM_V_BOX_WIDTH) || (ye - y < `AIM_V_BOX_WIDTH);
    endfunction

    task automatic check_pixel(input int x, input int y);
        rgb888_t     want;
        bit          hit;
        logic [15:0] p;
        hit  = 1'b0;
        want = '0;
        for (int b = 0; b < N_BOX; b++) begin
            if (!hit && on_box_border(m_act[b], x, y)) begin
                hit  = 1'b1;
                want = m_act[b].color;
            end
        end
        if (!hit) begin
            p      = m_img[y][x];
            want.r = {p[15:11], 3'b000};
            want.g = {p[10:5], 2'b00};
            want.b = {p[4:0], 3'b000};
        end
        n_checks++;
        if (o_hdmi_r !== want.r) begin
            report_mismatch($sformatf("o_hdmi_r at (%0d,%0d)", x, y), want.r, o_hdmi_r);
        end
        if (o_hdmi_g !== want.g) begin
            report_mismatch($sformatf("o_hdmi_g at (%0d,%0d)", x, y), want.g, o_hdmi_g);
        end
        if (o_hdmi_b !== want.b) begin
            report_mismatch($sformatf("o_hdmi_b at (%0d,%0d)", x, y), want.b, o_hdmi_b);
        end
    endtask

    task automatic end_of_frame();
        if (seen_vs) begin
            if (de_lines != V_ACT) begin
                n_err++;
                $display("Frame ended after %0d active lines instead of %0d", de_lines, V_ACT);
            end
            if (de_cnt != N_PIX) begin
                n_err++;
                $display("Frame ended after %0d active pixels instead of %0d", de_cnt, N_PIX);
            end
        end
        if (check_en) begin
            frames_done++;
        end
        // New settings take effect for the frame that follows.
        for (int b = 0; b < N_BOX; b++) begin
            m_act[b] = m_pend[b];
        end
        check_en = check_armed;
        de_cnt   = 0;
        de_lines = 0;
        seen_vs  = 1'b1;
    endtask

    always @(posedge clk) begin
        if (!i_rst) begin
            if (o_hdmi_vsync) begin
                vs_run++;
            end else if (vs_run != 0) begin
                if (vs_run != VS_WIDTH) begin
                    report_mismatch("o_hdmi_vsync width", VS_WIDTH, vs_run);
                end
                vs_run = 0;
                end_of_frame();
            end
            if (o_hdmi_hsync) begin
                hs_run++;
            end else if (hs_run != 0) begin
                if (hs_run != HS_WIDTH) begin
                    report_mismatch("o_hdmi_hsync width", HS_WIDTH, hs_run);
                end
                hs_run = 0;
            end
            if (o_hdmi_de) begin
                if (check_en && de_cnt < N_PIX) begin
                    check_pixel(de_cnt % H_ACT, de_cnt / H_ACT);
                end
                de_cnt++;
                de_run++;
            end else begin
                if (de_run != 0) begin
                    if (de_run != H_ACT) begin
                        report_mismatch("o_hdmi_de run length", H_ACT, de_run);
                    end
                    de_lines++;
                    de_run = 0;
                end
                if ({o_hdmi_r, o_hdmi_g, o_hdmi_b} !== 24'h0) begin
                    report_mismatch("o_hdmi_rgb in blanking", 24'h0,
                                    {o_hdmi_r, o_hdmi_g, o_hdmi_b});
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d errors", cycles, n_err);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic wait_frames(input int n);
        int target;
        target = frames_done + n;
        while (frames_done < target) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_de_line(input int line);
        while (de_cnt < line * H_ACT) begin
            @(negedge clk);
        end
    endtask

    task automatic reg_write(input int box, input box_reg_e field, input logic [23:0] data);
        i_reg_we    = 1'b1;
        i_reg_addr  = {box[0], field};
        i_reg_wdata = data;
        case (field)
            REG_XS:    m_pend[box].xs    = data[`AIM_X_W-1:0];
            REG_YS:    m_pend[box].ys    = data[`AIM_Y_W-1:0];
            REG_XE:    m_pend[box].xe    = data[`AIM_X_W-1:0];
            REG_YE:    m_pend[box].ye    = data[`AIM_Y_W-1:0];
            REG_COLOR: m_pend[box].color = data;
            REG_CTRL:  m_pend[box].en    = data[0];
            default:   ;
        endcase
        @(negedge clk);
        i_reg_we = 1'b0;
    endtask

    task automatic write_box(input int box, input int xs, input int ys, input int xe,
                             input int ye, input bit en, input logic [23:0] color);
        reg_write(box, REG_XS, 24'(xs));
        reg_write(box, REG_YS, 24'(ys));
        reg_write(box, REG_XE, 24'(xe));
        reg_write(box, REG_YE, 24'(ye));
        reg_write(box, REG_COLOR, color);
        reg_write(box, REG_CTRL, {23'd0, en});
    endtask

    task automatic random_boxes(input bit overlap);
        int xs;
        int ys;
        int xe;
        int ye;
        // Box 0 is always large enough to have interior pixels.
        xs = $urandom % 28;
        xe = xs + 4 + $urandom % (28 - xs);
        ys = $urandom % 13;
        ye = ys + 2 + $urandom % (14 - ys);
        write_box(0, xs, ys, xe, ye, 1'b1, 24'($urandom));
        if (overlap) begin
            // Box 1 starts inside box 0.
            xs = xs + $urandom % (xe - xs + 1);
            ys = ys + $urandom % (ye - ys + 1);
        end else begin
            xs = $urandom % H_ACT;
            ys = $urandom % V_ACT;
        end
        xe = xs + $urandom % (H_ACT - xs);
        ye = ys + $urandom % (V_ACT - ys);
        write_box(1, xs, ys, xe, ye, overlap || ($urandom % 2 == 1), 24'($urandom));
    endtask

    task automatic send_byte(input logic [7:0] data);
        if ($urandom % 8 == 0) begin
            i_cam_byte_en = 1'b0;
            @(negedge clk);
        end
        i_cam_byte_en = 1'b1;
        i_cam_data    = data;
        @(negedge clk);
    endtask

    task automatic send_cam_frame(input int n_rows, input int n_cols);
        logic [15:0] px;
        @(negedge clk);
        i_cam_vsync = 1'b1;
        repeat (2) @(negedge clk);
        i_cam_vsync = 1'b0;
        repeat (2) @(negedge clk);
        for (int row = 0; row < n_rows; row++) begin
            i_cam_href = 1'b1;
            for (int col = 0; col < n_cols; col++) begin
                px = 16'($urandom);
                send_byte(px[15:8]);
                send_byte(px[7:0]);
                if (row < V_ACT && col < H_ACT) begin
                    m_img[row][col] = px;
                end
            end
            i_cam_byte_en = 1'b0;
            i_cam_href    = 1'b0;
            repeat (2) @(negedge clk);
        end
    endtask

    initial begin
        int seed;
        i_rst         = 1'b1;
        i_cam_vsync   = 1'b0;
        i_cam_href    = 1'b0;
        i_cam_byte_en = 1'b0;
        i_cam_data    = 8'h00;
        i_reg_we      = 1'b0;
        i_reg_addr    = 4'h0;
        i_reg_wdata   = 24'h0;
        for (int b = 0; b < N_BOX; b++) begin
            m_pend[b] = '0;
            m_act[b]  = '0;
        end
        // No camera frame yet, so the whole picture is black.
        for (int y = 0; y < V_ACT; y++) begin
            for (int x = 0; x < H_ACT; x++) begin
                m_img[y][x] = 16'h0000;
            end
        end
        seed = $urandom(17507);
        repeat (5) @(negedge clk);
        i_rst = 1'b0;

        // Idle display, black picture and no boxes.
        check_armed = 1'b1;
        wait_frames(1);

        // Full camera frame, then one display frame.
        check_armed = 1'b0;
        check_en    = 1'b0;
        send_cam_frame(V_ACT, H_ACT);
        check_armed = 1'b1;
        wait_frames(1);

        // Overlapping boxes.
        wait_de_line(2);
        random_boxes(1'b1);
        wait_frames(2);

        // Mid-frame register writes apply one frame later.
        wait_de_line(8);
        random_boxes(1'b0);
        wait_frames(2);

        // Long lines and extra rows are dropped.
        check_armed = 1'b0;
        check_en    = 1'b0;
        send_cam_frame(V_ACT + 2, H_ACT + 8);
        check_armed = 1'b1;
        wait_frames(1);

        // New picture under the same boxes.
        check_armed = 1'b0;
        check_en    = 1'b0;
        send_cam_frame(V_ACT, H_ACT);
        check_armed = 1'b1;
        wait_frames(1);

        $display("Done: %0d frames, %0d pixel checks, %0d errors",
                 frames_done, n_checks, n_err);
        if (n_err == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+common
common/aim_pkg.sv
common/pix_if.sv
verilog/cam_capture.sv
verilog/frame_buffer.sv
display/video_timing.sv
display/box_regs.sv
display/draw_window.sv
verilog/aim_video_top.sv
sim/tb_aim_video_top.sv

// File: verilog/aim_video_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "aim_defines.svh"

module aim_video_top (
    input  wire         clk,
    input  wire         i_rst,
    input  wire         i_cam_vsync,
    input  wire         i_cam_href,
    input  wire         i_cam_byte_en,
    input  wire  [7:0]  i_cam_data,
    input  wire         i_reg_we,
    input  wire  [3:0]  i_reg_addr,
    input  wire  [23:0] i_reg_wdata,
    output logic        o_hdmi_hsync,
    output logic        o_hdmi_vsync,
    output logic        o_hdmi_de,
    output logic [7:0]  o_hdmi_r,
    output logic [7:0]  o_hdmi_g,
    output logic [7:0]  o_hdmi_b
);
    import aim_pkg::*;

    logic                       we;
    logic [`AIM_FB_AW-1:0]      waddr;
    rgb565_t                    wdata;
    logic [`AIM_FB_AW-1:0]      raddr;
    rgb565_t                    rdata;
    logic                       frame_start;
    box_cfg_t [`AIM_N_BOX-1:0]  boxes;

    pix_if disp_pix ();

    cam_capture u_cam_capture (
        .clk          (clk          ),
        .i_rst        (i_rst        ),
        .i_cam_vsync  (i_cam_vsync  ),
        .i_cam_href   (i_cam_href   ),
        .i_cam_byte_en(i_cam_byte_en),
        .i_cam_data   (i_cam_data   ),
        .o_we         (we           ),
        .o_waddr      (waddr        ),
        .o_wdata      (wdata        )
    );

    frame_buffer u_frame_buffer (
        .clk    (clk  ),
        .i_we   (we   ),
        .i_waddr(waddr),
        .i_wdata(wdata),
        .i_raddr(raddr),
        .o_rdata(rdata)
    );

    video_timing u_video_timing (
        .clk          (clk        ),
        .i_rst        (i_rst      ),
        .i_rdata      (rdata      ),
        .o_raddr      (raddr      ),
        .o_frame_start(frame_start),
        .o_pix        (disp_pix   )
    );

    box_regs u_box_regs (
        .clk          (clk        ),
        .i_rst        (i_rst      ),
        .i_reg_we     (i_reg_we   ),
        .i_reg_addr   (i_reg_addr ),
        .i_reg_wdata  (i_reg_wdata),
        .i_frame_start(frame_start),
        .o_boxes      (boxes      )
    );

    draw_window u_draw_window (
        .clk    (clk         ),
        .i_rst  (i_rst       ),
        .i_boxes(boxes       ),
        .i_pix  (disp_pix    ),
        .o_hsync(o_hdmi_hsync),
        .o_vsync(o_hdmi_vsync),
        .o_de   (o_hdmi_de   ),
        .o_r    (o_hdmi_r    ),
        .o_g    (o_hdmi_g    ),
        .o_b    (o_hdmi_b    )
    );

endmodule

`default_nettype wire

// File: verilog/cam_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "aim_defines.svh"

module cam_capture (
    input  wire                    clk,
    input  wire                    i_rst,
    input  wire                    i_cam_vsync,
    input  wire                    i_cam_href,
    input  wire                    i_cam_byte_en,
    input  wire  [7:0]             i_cam_data,
    output logic                   o_we,
    output logic [`AIM_FB_AW-1:0]  o_waddr,
    output aim_pkg::rgb565_t       o_wdata
);
    import aim_pkg::*;

    localparam int FB_AW = `AIM_FB_AW;

    cap_state_e          state;
    logic                vsync_q;
    logic                href_q;
    logic [7:0]          hi_byte;
    logic [`AIM_X_W-1:0] col_cnt;
    logic [`AIM_Y_W-1:0] row_cnt;
    logic                vsync_rise;
    logic                href_fall;
    logic                byte_ok;
    logic                in_frame;

    assign vsync_rise = i_cam_vsync && !vsync_q;
    assign href_fall  = href_q && !i_cam_href;
    assign byte_ok    = i_cam_href && i_cam_byte_en;

    // Counters saturate one past the edge, so overflow bytes never write.
    assign in_frame = (col_cnt < `AIM_H_ACTIVE) && (row_cnt < `AIM_V_ACTIVE);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            vsync_q <= 1'b0;
            href_q  <= 1'b0;
            state   <= CAP_IDLE;
            col_cnt <= '0;
            row_cnt <= '0;
            o_we    <= 1'b0;
        end else begin
            vsync_q <= i_cam_vsync;
            href_q  <= i_cam_href;
            o_we    <= 1'b0;
            if (vsync_rise) begin
                state   <= CAP_IDLE;
                col_cnt <= '0;
                row_cnt <= '0;
            end else if (href_fall) begin
                state   <= CAP_IDLE;
                col_cnt <= '0;
                if (row_cnt < `AIM_V_ACTIVE) begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end else begin
                case (state)
                    CAP_IDLE: begin
                        // First byte may come with the href edge itself.
                        if (i_cam_href) begin
                            state <= byte_ok ? CAP_LO : CAP_HI;
                        end
                    end
                    CAP_HI: begin
                        if (byte_ok) begin
                            state <= CAP_LO;
                        end
                    end
                    CAP_LO: begin
                        if (byte_ok) begin
                            state <= CAP_HI;
                            o_we  <= in_frame;
                            if (col_cnt < `AIM_H_ACTIVE) begin
                                col_cnt <= col_cnt + 1'b1;
                            end
                        end
                    end
                    default: state <= CAP_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_ok && (state != CAP_LO)) begin
            hi_byte <= i_cam_data;
        end
        if (byte_ok && (state == CAP_LO)) begin
            o_waddr <= FB_AW'(row_cnt) * FB_AW'(`AIM_H_ACTIVE) + FB_AW'(col_cnt);
            o_wdata <= {hi_byte, i_cam_data};
        end
    end

endmodule

`default_nettype wire

// File: verilog/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "aim_defines.svh"

module frame_buffer (
    input  wire                    clk,
    input  wire                    i_we,
    input  wire  [`AIM_FB_AW-1:0]  i_waddr,
    input  wire aim_pkg::rgb565_t  i_wdata,
    input  wire  [`AIM_FB_AW-1:0]  i_raddr,
    output aim_pkg::rgb565_t       o_rdata
);
    import aim_pkg::*;

    localparam int DEPTH = 1 << `AIM_FB_AW;

    rgb565_t mem [0:DEPTH-1];

    // The picture starts out black.
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Same address in the same cycle returns the old word.
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_raddr];
    end

endmodule

`default_nettype wire
